// ==== all.f ====
hdl/sbt_pkg.sv
hdl/sb_issue_if.sv
hdl/sb_clear_if.sv
hdl/issue_stage.sv
hdl/scoreboard_tracker.sv
hdl/long_op_pool.sv
hdl/long_op_completer.sv
hdl/sbt_top.sv
verif/sbt_tb.sv

// ==== hdl/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage
  import sbt_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic instr_valid,
  input  decode_s instr,
  input  logic [data_width-1:0] rs1_val,
  input  logic [imm_width-1:0] offset,
  input  logic flush,
  input  logic stall_all,
  input  isb_info_s [reg_els-1:0] int_sb,
  input  fsb_info_s [reg_els-1:0] float_sb,
  input  logic int_full,
  input  logic fp_full,
  output logic ready,
  sb_issue_if.source issue
);

  logic id_valid_r;
  decode_s id_r;
  logic [data_width-1:0] rs1_val_r;
  logic [imm_width-1:0] offset_r;
  region_e id_region;
  isb_info_s id_int_info;
  fsb_info_s id_fp_info;
  logic src_hazard;
  logic rd_hazard;
  logic pool_hazard;
  logic stall_id;
  logic advance;
  logic accept;

  // same classification the tracker and completer will apply
  assign id_region = addr_region(rs1_val_r, offset_r);
  assign id_int_info = int_reasons(id_r, id_region);
  assign id_fp_info = fp_reasons(id_r, id_region);

  assign src_hazard = (|int_sb[id_r.rs1]) | (|int_sb[id_r.rs2]);
  // both tables get rewritten at rd on advance
  assign rd_hazard = (|int_sb[id_r.rd]) | (|float_sb[id_r.rd]);
  assign pool_hazard = ((|id_int_info) & int_full) | ((|id_fp_info) & fp_full);
  assign stall_id = id_valid_r & (src_hazard | rd_hazard | pool_hazard);

  assign advance = id_valid_r & ~stall_id & ~stall_all & ~flush;
  // an instruction taken during flush is dropped
  assign ready = ~stall_all & (~id_valid_r | advance | flush);
  assign accept = instr_valid & ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_valid_r <= 1'b0;
    end else if (flush) begin
      id_valid_r <= 1'b0;
    end else if (ready) begin
      id_valid_r <= instr_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_r <= instr;
      rs1_val_r <= rs1_val;
      offset_r <= offset;
    end
  end

  assign issue.advance = advance;
  assign issue.id_r = id_r;
  assign issue.rs1_val = rs1_val_r;
  assign issue.offset = offset_r;

endmodule

// ==== hdl/long_op_completer.sv ====
`timescale 1ns/1ps

module long_op_completer
  import sbt_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  sb_issue_if.sink issue,
  sb_clear_if.source clr,
  output logic int_full,
  output logic fp_full
);

  region_e region;
  isb_info_s int_info;
  fsb_info_s fp_info;
  logic [lat_width-1:0] region_lat;
  logic [lat_width-1:0] int_lat;
  logic [lat_width-1:0] fp_lat;
  logic int_push;
  logic fp_push;
  int_op_s int_push_op;
  fp_op_s fp_push_op;
  logic int_done;
  logic fp_done;
  int_op_s int_done_op;
  fp_op_s fp_done_op;

  // class is needed here for the latency
  assign region = addr_region(issue.rs1_val, issue.offset);
  assign int_info = int_reasons(issue.id_r, region);
  assign fp_info = fp_reasons(issue.id_r, region);

  always_comb begin
    case (region)
      region_dram:   region_lat = lat_dram;
      region_global: region_lat = lat_global;
      default:       region_lat = lat_group;
    endcase
  end

  // divides take priority over the load latency
  assign int_lat = int_info.idiv ? lat_idiv : region_lat;
  assign fp_lat = fp_info.fdiv_fsqrt ? lat_fdiv : region_lat;

  assign int_push = issue.advance & (|int_info);
  assign fp_push = issue.advance & (|fp_info);
  assign int_push_op = '{rd: issue.id_r.rd, info: int_info};
  assign fp_push_op = '{rd: issue.id_r.rd, info: fp_info};

  // each pool owns one clear port, so whatever is offered is taken
  long_op_pool #(.entry_t(int_op_s)) int_pool (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push         (int_push),
    .push_entry   (int_push_op),
    .push_latency (int_lat),
    .pop          (int_done),
    .done_valid   (int_done),
    .done_entry   (int_done_op),
    .full         (int_full)
  );

  long_op_pool #(.entry_t(fp_op_s)) fp_pool (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .push         (fp_push),
    .push_entry   (fp_push_op),
    .push_latency (fp_lat),
    .pop          (fp_done),
    .done_valid   (fp_done),
    .done_entry   (fp_done_op),
    .full         (fp_full)
  );

  assign clr.int_clear = int_done;
  assign clr.int_clear_id = int_done_op.rd;
  assign clr.float_clear = fp_done;
  assign clr.float_clear_id = fp_done_op.rd;

endmodule

// ==== hdl/long_op_pool.sv ====
`timescale 1ns/1ps

module long_op_pool
  import sbt_pkg::*;
#(
  parameter type entry_t = int_op_s
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic push,
  input  entry_t push_entry,
  input  logic [lat_width-1:0] push_latency,
  input  logic pop,
  output logic done_valid,
  output entry_t done_entry,
  output logic full
);

  logic [pool_els-1:0] valid_r;
  entry_t entry_r [pool_els];
  logic [lat_width-1:0] cnt_r [pool_els];
  logic [pool_els-1:0] expired;
  logic [pool_idx_width-1:0] done_idx;
  logic [pool_idx_width-1:0] free_idx;
  logic do_push;
  logic do_pop;

  // scan downward so the lowest index is the one left standing
  always_comb begin
    done_idx = '0;
    free_idx = '0;
    for (int i = pool_els - 1; i >= 0; i--) begin
      expired[i] = valid_r[i] & (cnt_r[i] == '0);
      if (expired[i]) begin
        done_idx = pool_idx_width'(i);
      end
      if (!valid_r[i]) begin
        free_idx = pool_idx_width'(i);
      end
    end
  end

  assign done_valid = |expired;
  assign done_entry = entry_r[done_idx];
  assign full = &valid_r;
  assign do_push = push & ~full;
  assign do_pop = pop & done_valid;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r <= '0;
    end else begin
      if (do_pop) begin
        valid_r[done_idx] <= 1'b0;
      end
      if (do_push) begin
        valid_r[free_idx] <= 1'b1;
      end
    end
  end

  // counter holds at zero until the slot is popped
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < pool_els; i++) begin
      if (do_push && (free_idx == pool_idx_width'(i))) begin
        entry_r[i] <= push_entry;
        cnt_r[i] <= push_latency - 1'b1;
      end else if (cnt_r[i] != '0) begin
        cnt_r[i] <= cnt_r[i] - 1'b1;
      end
    end
  end

endmodule

// ==== hdl/sb_clear_if.sv ====
`timescale 1ns/1ps

interface sb_clear_if
  import sbt_pkg::*;
  ();

  logic int_clear;
  logic [reg_addr_width-1:0] int_clear_id;
  logic float_clear;
  logic [reg_addr_width-1:0] float_clear_id;

  modport source (
    output int_clear,
    output int_clear_id,
    output float_clear,
    output float_clear_id
  );

  modport sink (
    input int_clear,
    input int_clear_id,
    input float_clear,
    input float_clear_id
  );

endinterface

// ==== hdl/sb_issue_if.sv ====
`timescale 1ns/1ps

interface sb_issue_if
  import sbt_pkg::*;
  ();

  // decode slot moves to execute on this edge
  logic advance;
  decode_s id_r;
  logic [data_width-1:0] rs1_val;
  logic [imm_width-1:0] offset;

  modport source (
    output advance,
    output id_r,
    output rs1_val,
    output offset
  );

  modport sink (
    input advance,
    input id_r,
    input rs1_val,
    input offset
  );

endinterface

// ==== hdl/sbt_pkg.sv ====
package sbt_pkg;

  localparam int data_width = 32;
  localparam int reg_addr_width = 5;
  localparam int reg_els = 32;
  localparam int imm_width = 12;
  localparam int pool_els = 4;
  localparam int pool_idx_width = $clog2(pool_els);
  localparam int lat_width = 4;

  // issue to clear, in cycles, per long op class
  localparam logic [lat_width-1:0] lat_idiv = 4'd8;
  localparam logic [lat_width-1:0] lat_fdiv = 4'd12;
  localparam logic [lat_width-1:0] lat_dram = 4'd10;
  localparam logic [lat_width-1:0] lat_global = 4'd6;
  localparam logic [lat_width-1:0] lat_group = 4'd3;

  typedef enum logic [1:0] {
    region_local  = 2'b00,
    region_group  = 2'b01,
    region_global = 2'b10,
    region_dram   = 2'b11
  } region_e;

  typedef struct packed {
    logic is_load_op;
    logic write_rd;
    logic write_frd;
    logic is_amo_op;
    logic is_idiv_op;
    logic is_fp_op;
    logic is_fdiv_op;
    logic is_fsqrt_op;
    logic [reg_addr_width-1:0] rd;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
  } decode_s;

  typedef struct packed {
    logic idiv;
    logic remote_dram_load;
    logic remote_global_load;
    logic remote_group_load;
  } isb_info_s;

  typedef struct packed {
    logic fdiv_fsqrt;
    logic remote_dram_load;
    logic remote_global_load;
    logic remote_group_load;
  } fsb_info_s;

  typedef struct packed {
    logic [reg_addr_width-1:0] rd;
    isb_info_s info;
  } int_op_s;

  typedef struct packed {
    logic [reg_addr_width-1:0] rd;
    fsb_info_s info;
  } fp_op_s;

  // rs1 plus sign-extended offset, sorted by its top bits
  function automatic region_e addr_region(input logic [data_width-1:0] rs1_val,
                                          input logic [imm_width-1:0] offset);
    logic [data_width-1:0] addr;
    addr = rs1_val + {{(data_width-imm_width){offset[imm_width-1]}}, offset};
    if (addr[data_width-1]) begin
      return region_dram;
    end else if (addr[data_width-1 -: 2] == 2'b01) begin
      return region_global;
    end else if (addr[data_width-1 -: 3] == 3'b001) begin
      return region_group;
    end
    return region_local;
  endfunction

  function automatic isb_info_s int_reasons(input decode_s d, input region_e r);
    logic ld;
    isb_info_s info;
    // amo always returns a value to rd
    ld = (d.is_load_op & d.write_rd) | d.is_amo_op;
    info.idiv = d.is_idiv_op;
    info.remote_dram_load = ld & (r == region_dram);
    info.remote_global_load = ld & (r == region_global);
    info.remote_group_load = ld & (r == region_group);
    return info;
  endfunction

  function automatic fsb_info_s fp_reasons(input decode_s d, input region_e r);
    logic ld;
    fsb_info_s info;
    ld = d.is_load_op & d.write_frd;
    info.fdiv_fsqrt = d.is_fp_op & (d.is_fdiv_op | d.is_fsqrt_op);
    info.remote_dram_load = ld & (r == region_dram);
    info.remote_global_load = ld & (r == region_global);
    info.remote_group_load = ld & (r == region_group);
    return info;
  endfunction

endpackage

// ==== hdl/sbt_top.sv ====
`timescale 1ns/1ps

module sbt_top
  import sbt_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic instr_valid,
  input  logic is_load_op,
  input  logic write_rd,
  input  logic write_frd,
  input  logic is_amo_op,
  input  logic is_idiv_op,
  input  logic is_fp_op,
  input  logic is_fdiv_op,
  input  logic is_fsqrt_op,
  input  logic [reg_addr_width-1:0] rd,
  input  logic [reg_addr_width-1:0] rs1,
  input  logic [reg_addr_width-1:0] rs2,
  input  logic [data_width-1:0] rs1_val,
  input  logic [imm_width-1:0] offset,
  input  logic flush,
  input  logic stall_all,
  output logic ready,
  output isb_info_s [reg_els-1:0] int_sb_o,
  output fsb_info_s [reg_els-1:0] float_sb_o,
  output logic int_clear,
  output logic [reg_addr_width-1:0] int_clear_id,
  output logic float_clear,
  output logic [reg_addr_width-1:0] float_clear_id
);

  decode_s instr;
  logic int_full;
  logic fp_full;

  sb_issue_if issue_if ();
  sb_clear_if clear_if ();

  assign instr = '{
    is_load_op: is_load_op,
    write_rd: write_rd,
    write_frd: write_frd,
    is_amo_op: is_amo_op,
    is_idiv_op: is_idiv_op,
    is_fp_op: is_fp_op,
    is_fdiv_op: is_fdiv_op,
    is_fsqrt_op: is_fsqrt_op,
    rd: rd,
    rs1: rs1,
    rs2: rs2
  };

  issue_stage issue_stage_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rs1_val     (rs1_val),
    .offset      (offset),
    .flush       (flush),
    .stall_all   (stall_all),
    .int_sb      (int_sb_o),
    .float_sb    (float_sb_o),
    .int_full    (int_full),
    .fp_full     (fp_full),
    .ready       (ready),
    .issue       (issue_if)
  );

  scoreboard_tracker scoreboard_tracker_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .issue      (issue_if),
    .clr        (clear_if),
    .int_sb_o   (int_sb_o),
    .float_sb_o (float_sb_o)
  );

  long_op_completer long_op_completer_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .issue    (issue_if),
    .clr      (clear_if),
    .int_full (int_full),
    .fp_full  (fp_full)
  );

  assign int_clear = clear_if.int_clear;
  assign int_clear_id = clear_if.int_clear_id;
  assign float_clear = clear_if.float_clear;
  assign float_clear_id = clear_if.float_clear_id;

endmodule

// ==== hdl/scoreboard_tracker.sv ====
`timescale 1ns/1ps

module scoreboard_tracker
  import sbt_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  sb_issue_if.sink issue,
  sb_clear_if.sink clr,
  output isb_info_s [reg_els-1:0] int_sb_o,
  output fsb_info_s [reg_els-1:0] float_sb_o
);

  // int entry bits
  //   3 idiv
  //   2 remote dram load
  //   1 remote global load
  //   0 remote group load
  // float entry bits
  //   3 fdiv or fsqrt
  //   2..0 same load regions as int

  isb_info_s [reg_els-1:0] int_sb_r;
  fsb_info_s [reg_els-1:0] float_sb_r;
  region_e region;
  isb_info_s int_info;
  fsb_info_s fp_info;

  // effective address of the instruction leaving decode
  assign region = addr_region(issue.rs1_val, issue.offset);

  // local loads and plain ops end up as all zero
  assign int_info = int_reasons(issue.id_r, region);
  assign fp_info = fp_reasons(issue.id_r, region);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      int_sb_r <= '0;
      float_sb_r <= '0;
    end else begin
      if (issue.advance) begin
        int_sb_r[issue.id_r.rd] <= int_info;
        float_sb_r[issue.id_r.rd] <= fp_info;
      end
      // later assignment, so a clear to the same rd wins
      if (clr.int_clear) begin
        int_sb_r[clr.int_clear_id] <= '0;
      end
      if (clr.float_clear) begin
        float_sb_r[clr.float_clear_id] <= '0;
      end
    end
  end

  assign int_sb_o = int_sb_r;
  assign float_sb_o = float_sb_r;

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the scoreboard tracker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module sbt_tb -f all.f -o sbt_sim

./obj_dir/sbt_sim | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation failed"
  exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
echo "simulation passed"

// ==== verif/sbt_tb.sv ====
`timescale 1ns/1ps

module sbt_tb
  import sbt_pkg::*;
  ();

  // op kinds and address regions used by the stimulus
  localparam int op_plain = 0;
  localparam int op_int_load = 1;
  localparam int op_fp_load = 2;
  localparam int op_amo = 3;
  localparam int op_idiv = 4;
  localparam int op_fdiv = 5;
  localparam int op_fsqrt = 6;
  localparam int at_local = 0;
  localparam int at_group = 1;
  localparam int at_global = 2;
  localparam int at_dram = 3;
  localparam int random_ops = 200;
  // directed part plus a worst case wait of about 15 cycles per random op
  localparam int cycle_limit = 1000 + random_ops * 15;

  logic clk_i = 1'b0;
  logic reset_i;
  logic instr_valid;
  decode_s instr;
  logic [data_width-1:0] rs1_val;
  logic [imm_width-1:0] offset;
  logic flush;
  logic stall_all;
  logic ready;
  isb_info_s [reg_els-1:0] int_sb_o;
  fsb_info_s [reg_els-1:0] float_sb_o;
  logic int_clear;
  logic [reg_addr_width-1:0] int_clear_id;
  logic float_clear;
  logic [reg_addr_width-1:0] float_clear_id;

  logic [31:0] seed;
  logic shake;
  int errors;
  int tests_run;
  int tests_failed;
  int test_err_mark;
  int cycles = 0;

  // reference model state with index 0 for the int pool and 1 for the float pool
  isb_info_s [reg_els-1:0] m_int_sb;
  fsb_info_s [reg_els-1:0] m_fp_sb;
  logic m_id_valid;
  decode_s m_id;
  logic [data_width-1:0] m_val;
  logic [imm_width-1:0] m_off;
  logic slot_v [2][pool_els];
  logic [reg_addr_width-1:0] slot_rd [2][pool_els];
  int tmr [2][pool_els];

  always #10 clk_i = ~clk_i;

  sbt_top sbt_top_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_valid    (instr_valid),
    .is_load_op     (instr.is_load_op),
    .write_rd       (instr.write_rd),
    .write_frd      (instr.write_frd),
    .is_amo_op      (instr.is_amo_op),
    .is_idiv_op     (instr.is_idiv_op),
    .is_fp_op       (instr.is_fp_op),
    .is_fdiv_op     (instr.is_fdiv_op),
    .is_fsqrt_op    (instr.is_fsqrt_op),
    .rd             (instr.rd),
    .rs1            (instr.rs1),
    .rs2            (instr.rs2),
    .rs1_val        (rs1_val),
    .offset         (offset),
    .flush          (flush),
    .stall_all      (stall_all),
    .ready          (ready),
    .int_sb_o       (int_sb_o),
    .float_sb_o     (float_sb_o),
    .int_clear      (int_clear),
    .int_clear_id   (int_clear_id),
    .float_clear    (float_clear),
    .float_clear_id (float_clear_id)
  );

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    return int'(next_rand() >> 16) % n;
  endfunction

  function automatic decode_s make_op(input int kind, input int rd, input int rs1,
                                      input int rs2);
    decode_s d;
    d = '0;
    d.rd = reg_addr_width'(rd);
    d.rs1 = reg_addr_width'(rs1);
    d.rs2 = reg_addr_width'(rs2);
    case (kind)
      op_int_load: {d.is_load_op, d.write_rd} = 2'b11;
      op_fp_load:  {d.is_load_op, d.write_frd, d.is_fp_op} = 3'b111;
      op_amo:      {d.is_amo_op, d.write_rd} = 2'b11;
      op_idiv:     {d.is_idiv_op, d.write_rd} = 2'b11;
      op_fdiv:     {d.is_fp_op, d.is_fdiv_op, d.write_frd} = 3'b111;
      op_fsqrt:    {d.is_fp_op, d.is_fsqrt_op, d.write_frd} = 3'b111;
      default:     d.write_rd = 1'b1;
    endcase
    return d;
  endfunction

  function automatic logic [data_width-1:0] region_target(input int region);
    logic [31:0] r;
    r = next_rand();
    case (region)
      at_group:  return {3'b001, r[28:0]};
      at_global: return {2'b01, r[29:0]};
      at_dram:   return {1'b1, r[30:0]};
      default:   return {3'b000, r[28:0]};
    endcase
  endfunction

  // pending reasons as {divide, dram, global, group}
  function automatic logic [3:0] ref_reasons(input decode_s d, input logic [31:0] val,
                                             input logic [11:0] off, input logic fp);
    logic [31:0] addr;
    logic [2:0] where;
    logic ld;
    logic div;
    addr = val + {{20{off[11]}}, off};
    if (addr[31]) where = 3'b100;
    else if (addr[31:30] == 2'b01) where = 3'b010;
    else if (addr[31:29] == 3'b001) where = 3'b001;
    else where = 3'b000;
    if (fp) begin
      ld = d.is_load_op & d.write_frd;
      div = d.is_fp_op & (d.is_fdiv_op | d.is_fsqrt_op);
    end else begin
      ld = (d.is_load_op & d.write_rd) | d.is_amo_op;
      div = d.is_idiv_op;
    end
    return {div, ld ? where : 3'b000};
  endfunction

  function automatic int op_latency(input logic [3:0] r, input int pool);
    if (r[3]) return (pool == 0) ? 8 : 12;
    if (r[2]) return 10;
    if (r[1]) return 6;
    return 3;
  endfunction

  function automatic logic pool_busy();
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < pool_els; i++) begin
        if (slot_v[p][i]) return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic expect_equal(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
    assert (got == exp) else begin
      $display("ERR %s got %0h expected %0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == test_err_mark) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - test_err_mark);
    end
    test_err_mark = errors;
  endtask

  // starts and ends on a falling edge; holds the instruction until it is taken
  task automatic send(input decode_s d, input int region, input logic fl, output int waited);
    logic [data_width-1:0] addr;
    logic [imm_width-1:0] off;
    logic taken;
    addr = region_target(region);
    off = imm_width'(next_rand() >> 20);
    instr = d;
    offset = off;
    rs1_val = addr - {{(data_width-imm_width){off[imm_width-1]}}, off};
    flush = fl;
    instr_valid = 1'b1;
    stall_all = shake && (rand_below(8) == 0);
    waited = 0;
    do begin
      @(posedge clk_i);
      taken = ready;
      @(negedge clk_i);
      if (!taken) begin
        waited++;
        stall_all = shake && (rand_below(8) == 0);
      end
    end while (!taken);
    instr_valid = 1'b0;
    flush = 1'b0;
    stall_all = 1'b0;
  endtask

  task automatic drain();
    while (m_id_valid || pool_busy()) @(negedge clk_i);
    expect_equal("int_sb_o", int_sb_o, '0);
    expect_equal("float_sb_o", float_sb_o, '0);
  endtask

  task automatic hazard_case(input string what, input decode_s first, input int region,
                             input decode_s second, input int reg_id);
    int waited;
    send(first, region, 1'b0, waited);
    send(second, at_local, 1'b0, waited);
    assert (ready == 1'b0) else begin
      $display("%s hazard did not hold the instruction in decode", what);
      errors++;
    end
    while (!ready) @(negedge clk_i);
    assert (int_sb_o[reg_id] == '0 && float_sb_o[reg_id] == '0) else begin
      $display("%s hazard released while register %0d was still pending", what, reg_id);
      errors++;
    end
    drain();
  endtask

  // lockstep model checked against the DUT before each edge
  always @(posedge clk_i) begin : reference_model
    logic clr_v [2];
    logic [reg_addr_width-1:0] clr_id [2];
    int clr_slot [2];
    int free_slot [2];
    logic [3:0] reas [2];
    logic stall;
    logic adv;
    logic exp_ready;
    if (reset_i) begin
      m_int_sb = '0;
      m_fp_sb = '0;
      m_id_valid = 1'b0;
      m_id = '0;
      for (int p = 0; p < 2; p++) begin
        for (int i = 0; i < pool_els; i++) begin
          slot_v[p][i] = 1'b0;
        end
      end
    end else begin
      reas[0] = ref_reasons(m_id, m_val, m_off, 1'b0);
      reas[1] = ref_reasons(m_id, m_val, m_off, 1'b1);
      stall = (|m_int_sb[m_id.rs1]) | (|m_int_sb[m_id.rs2]) | (|m_int_sb[m_id.rd]) |
              (|m_fp_sb[m_id.rd]);
      for (int p = 0; p < 2; p++) begin
        clr_v[p] = 1'b0;
        clr_id[p] = '0;
        clr_slot[p] = 0;
        free_slot[p] = -1;
        // lowest index wins
        for (int i = pool_els - 1; i >= 0; i--) begin
          if (slot_v[p][i] && tmr[p][i] == 1) begin
            clr_v[p] = 1'b1;
            clr_id[p] = slot_rd[p][i];
            clr_slot[p] = i;
          end
          if (!slot_v[p][i]) free_slot[p] = i;
        end
        if (reas[p] != 4'd0 && free_slot[p] < 0) stall = 1'b1;
      end
      stall = stall & m_id_valid;
      adv = m_id_valid & ~stall & ~stall_all & ~flush;
      exp_ready = ~stall_all & (~m_id_valid | adv | flush);

      expect_equal("ready", ready, exp_ready);
      expect_equal("int_sb_o", int_sb_o, m_int_sb);
      expect_equal("float_sb_o", float_sb_o, m_fp_sb);
      expect_equal("int_clear", int_clear, clr_v[0]);
      expect_equal("float_clear", float_clear, clr_v[1]);
      if (clr_v[0]) expect_equal("int_clear_id", int_clear_id, clr_id[0]);
      if (clr_v[1]) expect_equal("float_clear_id", float_clear_id, clr_id[1]);

      // timers run down to their last pending cycle and wait there
      for (int p = 0; p < 2; p++) begin
        for (int i = 0; i < pool_els; i++) begin
          if (slot_v[p][i] && tmr[p][i] > 1) tmr[p][i]--;
        end
        if (clr_v[p]) slot_v[p][clr_slot[p]] = 1'b0;
      end
      if (adv) begin
        m_int_sb[m_id.rd] = reas[0];
        m_fp_sb[m_id.rd] = reas[1];
        for (int p = 0; p < 2; p++) begin
          if (reas[p] != 4'd0) begin
            slot_v[p][free_slot[p]] = 1'b1;
            slot_rd[p][free_slot[p]] = m_id.rd;
            tmr[p][free_slot[p]] = op_latency(reas[p], p);
          end
        end
      end
      if (clr_v[0]) m_int_sb[clr_id[0]] = '0;
      if (clr_v[1]) m_fp_sb[clr_id[1]] = '0;
      if (flush) begin
        m_id_valid = 1'b0;
      end else if (exp_ready) begin
        m_id_valid = instr_valid;
        if (instr_valid) begin
          m_id = instr;
          m_val = rs1_val;
          m_off = offset;
        end
      end
    end
  end

  // model tables are settled by the falling edge
  int_clear_pending_a: assert property (@(negedge clk_i) disable iff (reset_i)
      int_clear |-> (m_int_sb[int_clear_id] != '0)) else begin
    $display("int clear for register %0d that has nothing pending", int_clear_id);
    errors++;
  end

  float_clear_pending_a: assert property (@(negedge clk_i) disable iff (reset_i)
      float_clear |-> (m_fp_sb[float_clear_id] != '0)) else begin
    $display("float clear for register %0d that has nothing pending", float_clear_id);
    errors++;
  end

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin : stimulus
    int waited;
    seed = 32'd6;
    shake = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    test_err_mark = 0;
    reset_i = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    rs1_val = '0;
    offset = '0;
    flush = 1'b0;
    stall_all = 1'b0;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    @(negedge clk_i);
    expect_equal("int_sb_o", int_sb_o, '0);
    expect_equal("float_sb_o", float_sb_o, '0);
    expect_equal("ready", ready, 1'b1);
    expect_equal("int_clear", int_clear, 1'b0);
    expect_equal("float_clear", float_clear, 1'b0);
    end_test("reset state");

    // one load per region in each file and then an amo and a local load
    for (int r = at_group; r <= at_dram; r++) begin
      send(make_op(op_int_load, r, 0, 0), r, 1'b0, waited);
      drain();
      send(make_op(op_fp_load, r + 8, 0, 0), r, 1'b0, waited);
      drain();
    end
    send(make_op(op_amo, 12, 0, 0), at_global, 1'b0, waited);
    drain();
    send(make_op(op_int_load, 13, 0, 0), at_local, 1'b0, waited);
    drain();
    end_test("remote loads");

    send(make_op(op_idiv, 14, 0, 0), at_local, 1'b0, waited);
    drain();
    send(make_op(op_fdiv, 15, 0, 0), at_local, 1'b0, waited);
    drain();
    send(make_op(op_fsqrt, 16, 0, 0), at_local, 1'b0, waited);
    drain();
    end_test("divide and sqrt");

    hazard_case("rs1", make_op(op_idiv, 5, 0, 0), at_local,
                make_op(op_plain, 20, 5, 0), 5);
    hazard_case("rs2", make_op(op_int_load, 5, 0, 0), at_dram,
                make_op(op_plain, 20, 0, 5), 5);
    hazard_case("rd", make_op(op_fp_load, 6, 0, 0), at_global,
                make_op(op_plain, 6, 0, 0), 6);
    // kill the idiv while it sits in decode
    send(make_op(op_idiv, 9, 0, 0), at_local, 1'b0, waited);
    flush = 1'b1;
    @(negedge clk_i);
    flush = 1'b0;
    send(make_op(op_idiv, 10, 0, 0), at_local, 1'b1, waited);
    repeat (3) @(negedge clk_i);
    expect_equal("int_sb_o[9]", int_sb_o[9], '0);
    expect_equal("int_sb_o[10]", int_sb_o[10], '0);
    drain();
    end_test("hazards and flush");

    // five dram loads back to back so the last one finds the pool full
    for (int k = 1; k <= 5; k++) begin
      send(make_op(op_int_load, k + 20, 0, 0), at_dram, 1'b0, waited);
    end
    send(make_op(op_plain, 26, 0, 0), at_local, 1'b0, waited);
    assert (waited > 0) else begin
      $display("ready stayed high with five operations for one pool");
      errors++;
    end
    drain();
    shake = 1'b1;
    for (int n = 0; n < random_ops; n++) begin
      send(make_op(rand_below(7), rand_below(8), rand_below(8), rand_below(8)),
           rand_below(4), rand_below(16) == 0, waited);
      if (rand_below(4) == 0) @(negedge clk_i);
    end
    shake = 1'b0;
    drain();
    end_test("pool full and random mix");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
